//--- design/iwm_pkg.sv
// Shared IWM read-side types, window timing constants and register-select encoding
`default_nettype none

package iwm_pkg;

    // ========================================================================
    // Constants
    // ========================================================================

    localparam int BYTE_W = 8;                       // Data byte width

    // Window lengths in 7 MHz enable cycles
    localparam logic [5:0] WINDOW_SHORT = 6'd14;     // 3.5-inch, or 5.25-inch fast
    localparam logic [5:0] WINDOW_LONG  = 6'd28;     // 5.25-inch slow
    localparam logic [5:0] HALF_SHORT   = 6'd7;
    localparam logic [5:0] HALF_LONG    = 6'd14;

    // CLK_14M cycles from an accepted async read to the data clear
    localparam logic [5:0] ASYNC_CLEAR_CYCLES = 6'd50;

    // Mode register bit positions
    localparam int MODE_ASYNC_BIT = 1;               // 1 = asynchronous handshake
    localparam int MODE_FAST_BIT  = 3;               // 1 = short windows on 5.25-inch

    localparam logic [BYTE_W-1:0] HANDSHAKE_VALUE = 8'h80;  // Write side always ready

    // ========================================================================
    // Types
    // ========================================================================

    // CPU access to the $C0E0-$C0EF block
    typedef struct packed {
        logic [3:0] addr;       // Soft-switch offset
        logic       rd;         // Read strobe
        logic       phi2_en;    // Valid part of the bus cycle
    } iwm_bus_t;

    // Latched soft-switch state
    typedef struct packed {
        logic             q6;
        logic             q7;
        logic [BYTE_W-1:0] mode;
    } iwm_switch_t;

    // Status of the selected drive
    typedef struct packed {
        logic motor_active;     // Motor commanded on
        logic motor_spinning;   // Physical spindle state
        logic disk_ready;       // Track data valid
        logic disk_mounted;     // Image loaded
        logic is_35_inch;       // 0 = 5.25-inch
        logic sense;            // Status sense line
    } iwm_drive_t;

    // Register chosen by {Q7,Q6}
    typedef enum logic [1:0] {
        sel_data      = 2'b00,
        sel_status    = 2'b01,
        sel_handshake = 2'b10,
        sel_ones      = 2'b11
    } reg_sel_t;

endpackage

`default_nettype wire

//--- design/iwm_flux_window.sv
// Flux edge capture, read window state machine and read shift register
`timescale 1ns/10ps
`default_nettype none

module iwm_flux_window (
    input  wire                          CLK_14M,
    input  wire                          RESET,
    input  wire                          clk_7m_en,        // 7 MHz state machine enable
    input  wire                          flux_transition,  // Pulse per flux reversal
    input  iwm_pkg::iwm_drive_t          drive,
    input  iwm_pkg::iwm_switch_t         sw,
    input  wire                          decoder_reset,    // Force machine to idle
    output logic [iwm_pkg::BYTE_W-1:0]   rsh,              // Read shift register
    output logic                         byte_completing   // MSB set while decoding
);

    typedef enum logic [1:0] {
        st_idle  = 2'd0,
        st_edge0 = 2'd1,    // Waiting for a flux in the window
        st_edge1 = 2'd2     // Flux seen, waiting out the half window
    } rd_state_t;

    rd_state_t   state;
    logic [5:0]  win_cnt;       // Window countdown in 7 MHz cycles
    logic        prev_flux;
    logic        flux_seen;     // Edge caught at 14 MHz, consumed at 7 MHz
    logic        flux_pending;  // Edge that arrived during the half window

    wire active     = drive.motor_spinning && drive.disk_ready;
    wire flux_edge  = flux_transition && !prev_flux;
    wire short_win  = drive.is_35_inch || sw.mode[iwm_pkg::MODE_FAST_BIT];

    wire [5:0] full_window = short_win ? iwm_pkg::WINDOW_SHORT : iwm_pkg::WINDOW_LONG;
    wire [5:0] half_window = short_win ? iwm_pkg::HALF_SHORT : iwm_pkg::HALF_LONG;

    assign byte_completing = rsh[iwm_pkg::BYTE_W-1] && active;

    // ========================================================================
    // Window state machine
    // ========================================================================

    always_ff @(posedge CLK_14M or posedge RESET) begin
        if (RESET) begin
            state        <= st_idle;
            win_cnt      <= 6'd0;
            rsh          <= '0;
            prev_flux    <= 1'b0;
            flux_seen    <= 1'b0;
            flux_pending <= 1'b0;
        end else begin
            prev_flux <= flux_transition;
            if (flux_edge)
                flux_seen <= 1'b1;              // Never miss a short pulse

            if (clk_7m_en && active) begin
                case (state)
                    st_idle: begin
                        state     <= st_edge0;
                        win_cnt   <= full_window;
                        rsh       <= '0;
                        flux_seen <= 1'b0;      // Drop stale edges on start
                    end
                    st_edge0: begin
                        if (flux_seen || flux_pending) begin
                            state        <= st_edge1;
                            win_cnt      <= half_window;
                            flux_seen    <= 1'b0;
                            flux_pending <= 1'b0;
                        end else if (win_cnt == 6'd1) begin
                            rsh     <= {rsh[iwm_pkg::BYTE_W-2:0], 1'b0};  // No flux, a 0
                            win_cnt <= full_window;
                        end else begin
                            win_cnt <= win_cnt - 6'd1;
                        end
                    end
                    st_edge1: begin
                        // Hold an early flux for the next window
                        if (flux_seen) begin
                            flux_pending <= 1'b1;
                            flux_seen    <= 1'b0;
                        end
                        if (win_cnt == 6'd1) begin
                            rsh     <= {rsh[iwm_pkg::BYTE_W-2:0], 1'b1};
                            state   <= st_edge0;
                            win_cnt <= full_window;
                        end else begin
                            win_cnt <= win_cnt - 6'd1;
                        end
                    end
                    default: state <= st_idle;
                endcase

                // Data register takes the byte on this cycle
                if (rsh[iwm_pkg::BYTE_W-1])
                    rsh <= '0;
            end

            // Drive stopped or track invalid
            if (!active) begin
                state        <= st_idle;
                win_cnt      <= 6'd0;
                flux_seen    <= 1'b0;
                flux_pending <= 1'b0;
            end

            if (decoder_reset)
                state <= st_idle;               // Mode change restarts decode
        end
    end

endmodule

`default_nettype wire

//--- design/iwm_data_latch.sv
// Data register, bit-7 acknowledge flag and same-cycle bypass of a completing byte
`timescale 1ns/10ps
`default_nettype none

module iwm_data_latch (
    input  wire                          CLK_14M,
    input  wire                          RESET,
    input  wire [iwm_pkg::BYTE_W-1:0]    rsh,
    input  wire                          byte_completing,
    input  wire                          data_clear,      // Read mode entered
    input  wire                          ack_set,         // Valid async read accepted
    input  wire                          async_clear,     // Async countdown expired
    output logic [iwm_pkg::BYTE_W-1:0]   effective_raw,   // Data or bypassed rsh
    output logic [iwm_pkg::BYTE_W-1:0]   effective_data   // Raw with bit 7 masked if acked
);

    logic [iwm_pkg::BYTE_W-1:0] data_reg;
    logic                       ack;        // Bit 7 already handed to the CPU
    logic                       ack_eff;

    // ========================================================================
    // Data register and acknowledge
    // ========================================================================

    always_ff @(posedge CLK_14M or posedge RESET) begin
        if (RESET) begin
            data_reg <= '0;
            ack      <= 1'b0;
        end else begin
            if (byte_completing) begin
                data_reg <= rsh;                // New byte beats any clear
                ack      <= 1'b0;
            end else if (data_clear || async_clear) begin
                data_reg <= '0;
                ack      <= 1'b0;
            end
            if (ack_set)
                ack <= 1'b1;                    // Read in progress wins
        end
    end

    // Bypass so a read in the completing cycle sees the new byte
    always_comb begin
        effective_raw  = byte_completing ? rsh : data_reg;
        ack_eff        = ack && !byte_completing;
        effective_data = effective_raw;
        if (ack_eff)
            effective_data[iwm_pkg::BYTE_W-1] = 1'b0;
    end

endmodule

`default_nettype wire

//--- design/iwm_read_ctrl.sv
// Motor and mode edge control, once-per-read detection and asynchronous clear countdown
`timescale 1ns/10ps
`default_nettype none

module iwm_read_ctrl (
    input  wire                          CLK_14M,
    input  wire                          RESET,
    input  iwm_pkg::iwm_bus_t            bus,
    input  iwm_pkg::iwm_switch_t         sw,
    input  iwm_pkg::iwm_drive_t          drive,
    input  iwm_pkg::reg_sel_t            sel,             // Immediate Q7/Q6 select
    input  wire [iwm_pkg::BYTE_W-1:0]    effective_raw,
    input  wire                          byte_completing,
    output logic                         decoder_reset,
    output logic                         data_clear,
    output logic                         ack_set,
    output logic                         async_clear
);

    logic       motor_was_on;   // Motor command last cycle
    logic       rw_mode;        // 1 while in write mode
    logic       rd_latched;     // Current strobe already handled
    logic       bc_prev;        // byte_completing last cycle
    logic [5:0] async_cnt;      // Cycles left to the async clear

    wire is_async   = sw.mode[iwm_pkg::MODE_ASYNC_BIT];

    // Read mode from standstill, or Q7 dropped out of write mode
    wire enter_read = drive.motor_active && !motor_was_on && !sw.q7 && !drive.motor_spinning;
    wire leave_write = drive.motor_active && motor_was_on && rw_mode && !sw.q7;

    wire rd_accept  = bus.rd && bus.phi2_en && !rd_latched;  // First phi2 of strobe
    wire data_read  = rd_accept && (sel == iwm_pkg::sel_data);
    wire valid_read = data_read && drive.motor_active && is_async &&
                      effective_raw[iwm_pkg::BYTE_W-1];
    wire bc_rise    = byte_completing && !bc_prev;

    assign data_clear    = enter_read || leave_write;
    assign decoder_reset = enter_read || leave_write;
    assign ack_set       = valid_read;
    assign async_clear   = (async_cnt == 6'd1) && is_async;

    // ========================================================================
    // Mode tracking
    // ========================================================================

    always_ff @(posedge CLK_14M or posedge RESET) begin
        if (RESET) begin
            motor_was_on <= 1'b0;
            rw_mode      <= 1'b0;
        end else begin
            motor_was_on <= drive.motor_active;
            if (enter_read || leave_write)
                rw_mode <= 1'b0;
            else if (drive.motor_active && sw.q7 && !rw_mode)
                rw_mode <= 1'b1;
            else if (!drive.motor_active && motor_was_on)
                rw_mode <= 1'b0;                // Motor command dropped
        end
    end

    // ========================================================================
    // Read detection and async countdown
    // ========================================================================

    always_ff @(posedge CLK_14M or posedge RESET) begin
        if (RESET) begin
            rd_latched <= 1'b0;
            bc_prev    <= 1'b0;
            async_cnt  <= 6'd0;
        end else begin
            bc_prev <= byte_completing;
            if (!bus.rd)
                rd_latched <= 1'b0;
            else if (rd_accept)
                rd_latched <= 1'b1;

            if (async_cnt != 6'd0)
                async_cnt <= async_cnt - 6'd1;
            if (bc_rise || !drive.motor_spinning || !drive.disk_ready)
                async_cnt <= 6'd0;              // New byte or drive stopped

            // Start, or restart when the read meets a fresh byte
            if (valid_read && (async_cnt == 6'd0 || byte_completing))
                async_cnt <= iwm_pkg::ASYNC_CLEAR_CYCLES;
        end
    end

endmodule

`default_nettype wire

//--- design/iwm_bus_read.sv
// Immediate Q6/Q7 decode, status byte assembly and CPU read data multiplexer
`timescale 1ns/10ps
`default_nettype none

module iwm_bus_read (
    input  iwm_pkg::iwm_bus_t            bus,
    input  iwm_pkg::iwm_switch_t         sw,
    input  iwm_pkg::iwm_drive_t          drive,
    input  wire [iwm_pkg::BYTE_W-1:0]    effective_data,
    output iwm_pkg::reg_sel_t            sel,
    output logic [iwm_pkg::BYTE_W-1:0]   data_out
);

    logic                       imm_q6;
    logic                       imm_q7;
    logic [iwm_pkg::BYTE_W-1:0] status;

    // ========================================================================
    // Register select and read mux
    // ========================================================================

    always_comb begin
        // Access to 0xC-0xF overrides the latch for this access only
        imm_q6 = (bus.addr[3:1] == 3'b110) ? bus.addr[0] : sw.q6;
        imm_q7 = (bus.addr[3:1] == 3'b111) ? bus.addr[0] : sw.q7;
        sel    = iwm_pkg::reg_sel_t'({imm_q7, imm_q6});

        // Sense, reserved 0, motor on with disk, mode[4:0]
        status = {drive.sense, 1'b0, drive.motor_active && drive.disk_mounted,
                  sw.mode[4:0]};

        case (sel)
            iwm_pkg::sel_data:
                data_out = drive.motor_active ? effective_data : 8'hFF;  // Off reads 0xFF
            iwm_pkg::sel_status:    data_out = status;
            iwm_pkg::sel_handshake: data_out = iwm_pkg::HANDSHAKE_VALUE;
            default:                data_out = 8'hFF;
        endcase
    end

endmodule

`default_nettype wire

//--- design/iwm_flux_top.sv
// Top level of the IWM read path, wiring control, flux window, data latch and bus read
`timescale 1ns/10ps
`default_nettype none

module iwm_flux_top (
    input  wire                          CLK_14M,
    input  wire                          RESET,
    input  wire                          clk_7m_en,
    input  iwm_pkg::iwm_bus_t            bus,
    input  iwm_pkg::iwm_switch_t         sw,
    input  iwm_pkg::iwm_drive_t          drive,
    input  wire                          flux_transition,
    output logic [iwm_pkg::BYTE_W-1:0]   data_out
);

    logic [iwm_pkg::BYTE_W-1:0] rsh;
    logic                       byte_completing;
    logic                       decoder_reset;
    logic                       data_clear;
    logic                       ack_set;
    logic                       async_clear;
    logic [iwm_pkg::BYTE_W-1:0] effective_raw;
    logic [iwm_pkg::BYTE_W-1:0] effective_data;
    iwm_pkg::reg_sel_t          sel;

    // ========================================================================
    // Control
    // ========================================================================

    iwm_read_ctrl u_ctrl (
        .CLK_14M, .RESET, .bus, .sw, .drive, .sel, .effective_raw, .byte_completing,
        .decoder_reset, .data_clear, .ack_set, .async_clear
    );

    // ========================================================================
    // Datapath
    // ========================================================================

    iwm_flux_window u_window (
        .CLK_14M, .RESET, .clk_7m_en, .flux_transition, .drive, .sw, .decoder_reset,
        .rsh, .byte_completing
    );

    iwm_data_latch u_latch (
        .CLK_14M, .RESET, .rsh, .byte_completing, .data_clear, .ack_set, .async_clear,
        .effective_raw, .effective_data
    );

    iwm_bus_read u_bus (
        .bus, .sw, .drive, .effective_data, .sel, .data_out
    );

endmodule

`default_nettype wire

//--- bench/iwm_tb_model.svh
// Testbench LCG, register reference model, flux bit-cell encoder and typed compare tasks
`ifndef IWM_TB_MODEL_SVH
`define IWM_TB_MODEL_SVH
`default_nettype none

// ============================================================================
// Reference model
// ============================================================================

// Classic 32-bit LCG step
function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
endfunction

// Register picked by the access, with the 0xC-0xF override
function automatic iwm_pkg::reg_sel_t sel_model(input logic [3:0] addr,
                                                input logic q6, input logic q7);
    logic q6_now;
    logic q7_now;
    q6_now = q6;
    q7_now = q7;
    if (addr == 4'hC || addr == 4'hD)
        q6_now = addr[0];                   // Q6 off/on
    if (addr == 4'hE || addr == 4'hF)
        q7_now = addr[0];                   // Q7 off/on
    return iwm_pkg::reg_sel_t'({q7_now, q6_now});
endfunction

// Expected read value for a register, given mode, drive and the data byte held
function automatic logic [7:0] expected_reg(input iwm_pkg::reg_sel_t sel,
                                            input logic [7:0] mode,
                                            input iwm_pkg::iwm_drive_t drv,
                                            input logic [7:0] data_byte);
    case (sel)
        iwm_pkg::sel_data:
            return drv.motor_active ? data_byte : 8'hFF;    // Motor off floats high
        iwm_pkg::sel_status:
            return {drv.sense, 1'b0, drv.motor_active & drv.disk_mounted, mode[4:0]};
        iwm_pkg::sel_handshake:
            return 8'h80;                   // Write side is always ready
        default:
            return 8'hFF;
    endcase
endfunction

// ============================================================================
// Flux encoder
// ============================================================================

// One bit cell of 2*win clocks, pulse at the cell start for a 1
task automatic send_cell(input logic b, input int win);
    @(posedge CLK_14M);
    #1;
    flux_transition = b;
    @(posedge CLK_14M);
    #1;
    flux_transition = 1'b0;
    repeat (2 * win - 2) @(posedge CLK_14M);
endtask

task automatic send_byte(input logic [7:0] b, input int win);
    for (int i = 7; i >= 0; i--)
        send_cell(b[i], win);               // MSB first, as on the track
endtask

task automatic idle_cells(input int n, input int win);
    repeat (n * 2 * win) @(posedge CLK_14M);
endtask

// ============================================================================
// Compare tasks
// ============================================================================

task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
        $display("ERR %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
        fail_run("Data mismatch");
    end
endtask

task automatic check_sel(input string name, input iwm_pkg::reg_sel_t got,
                         input iwm_pkg::reg_sel_t exp);
    if (got !== exp) begin
        $display("ERR %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
        fail_run("Register select mismatch");
    end
endtask

`default_nettype wire
`endif

//--- bench/iwm_flux_tb.sv
// Testbench top: clock, reset, stimulus, compare process and watchdog for the IWM read path
`timescale 1ns/10ps
`default_nettype none

module iwm_flux_tb;

    localparam int CLK_PERIOD  = 8;
    localparam int NUM_BYTES   = 13;                                // Bytes decoded in all tests
    localparam int WATCHDOG_NS = NUM_BYTES * 8 * 56 * CLK_PERIOD + 20000;
    localparam logic [31:0] SEED = 32'd27870;

    logic                  CLK_14M;
    logic                  RESET;
    logic                  clk_7m_en;
    logic                  flux_transition;
    iwm_pkg::iwm_bus_t     bus;
    iwm_pkg::iwm_switch_t  sw;
    iwm_pkg::iwm_drive_t   drive;
    wire  [7:0]            data_out;

    logic                  chk_data;        // Compare data_out on this cycle
    logic                  chk_sel;
    logic [7:0]            exp_data;
    iwm_pkg::reg_sel_t     exp_sel;
    logic [31:0]           rng;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "Run stopped at first error");
    endtask

`include "iwm_tb_model.svh"

    iwm_flux_top uut (
        .CLK_14M, .RESET, .clk_7m_en, .bus, .sw, .drive, .flux_transition, .data_out
    );

    // ========================================================================
    // Clock, 7 MHz enable, watchdog
    // ========================================================================

    initial begin
        CLK_14M = 1'b0;
        forever #(CLK_PERIOD / 2) CLK_14M = ~CLK_14M;
    end

    initial begin
        clk_7m_en = 1'b0;
        forever begin
            @(posedge CLK_14M);
            #1;
            clk_7m_en = ~clk_7m_en;         // Half rate of CLK_14M
        end
    end

    initial begin
        #(WATCHDOG_NS);
        fail_run("Timeout: the tests did not finish within the watchdog time");
    end

    // Outputs sampled mid-cycle, well clear of the drive edge
    initial begin : compare_proc
        forever begin
            @(negedge CLK_14M);
            if (chk_data)
                check_byte("data_out", data_out, exp_data);
            if (chk_sel)
                check_sel("uut.sel", uut.sel, exp_sel);
        end
    end

    // ========================================================================
    // Stimulus helpers
    // ========================================================================

    // One-cycle read strobe with expected value from the model
    task automatic read_reg(input logic [3:0] addr, input logic [7:0] data_byte);
        @(posedge CLK_14M);
        #1;
        bus.addr    = addr;
        bus.rd      = 1'b1;
        bus.phi2_en = 1'b1;
        exp_sel     = sel_model(addr, sw.q6, sw.q7);
        exp_data    = expected_reg(exp_sel, sw.mode, drive, data_byte);
        chk_data    = 1'b1;
        chk_sel     = 1'b1;
        @(posedge CLK_14M);
        #1;
        bus.rd      = 1'b0;
        bus.phi2_en = 1'b0;
        chk_data    = 1'b0;
        chk_sel     = 1'b0;
    endtask

    task automatic next_random_byte(output logic [7:0] b);
        rng = lcg_step(rng);
        b   = rng[23:16] | 8'h80;           // Disk bytes always have the MSB set
    endtask

    // Watch the data register without a strobe until a valid byte shows
    task automatic wait_data_valid();
        int n;
        n = 0;
        do begin
            @(posedge CLK_14M);
            #2;
            n++;
        end while (!data_out[7] && n < 200);
        if (!data_out[7])
            fail_run("No valid byte appeared in the data register");
    endtask

    task automatic decode_and_check(input int win, output logic [7:0] b);
        next_random_byte(b);
        send_byte(b, win);
        idle_cells(1, win);                 // Let the data register take it
        wait_data_valid();
        read_reg(4'h0, b);
    endtask

    // ========================================================================
    // Main sequence
    // ========================================================================

    initial begin
        logic [7:0] b;
        RESET = 1'b1;
        flux_transition = 1'b0;
        bus = '0;
        sw = '0;
        drive = '0;
        chk_data = 1'b0;
        chk_sel = 1'b0;
        exp_data = 8'h00;
        exp_sel = iwm_pkg::sel_data;
        rng = SEED;
        repeat (2) @(posedge CLK_14M);
        #1;
        RESET = 1'b0;

        // Register mux with random mode, sense, latches and address
        drive.motor_active = 1'b1;
        drive.disk_mounted = 1'b1;
        for (int i = 0; i < 32; i++) begin
            rng = lcg_step(rng);
            sw.mode     = rng[15:8];
            drive.sense = rng[16];
            sw.q6       = rng[17];
            sw.q7       = rng[18];
            read_reg(rng[23:20], 8'h00);    // Data register still empty
        end
        sw = '0;
        drive.motor_active = 1'b0;
        read_reg(4'h0, 8'h00);              // Motor command off
        drive.motor_active = 1'b1;

        // Synchronous decode, 3.5-inch windows
        drive.is_35_inch     = 1'b1;
        drive.disk_ready     = 1'b1;
        drive.motor_spinning = 1'b1;
        idle_cells(3, 14);
        repeat (4) decode_and_check(14, b);

        // 5.25-inch slow, then fast mode
        drive.is_35_inch = 1'b0;
        idle_cells(2, 28);
        repeat (3) decode_and_check(28, b);
        sw.mode[iwm_pkg::MODE_FAST_BIT] = 1'b1;
        idle_cells(2, 14);
        repeat (3) decode_and_check(14, b);

        // Asynchronous handshake
        sw.mode = 8'h00;
        sw.mode[iwm_pkg::MODE_ASYNC_BIT] = 1'b1;
        drive.is_35_inch = 1'b1;
        idle_cells(2, 14);
        decode_and_check(14, b);            // First read sees bit 7
        read_reg(4'h0, b & 8'h7F);          // Acknowledged
        repeat (int'(iwm_pkg::ASYNC_CLEAR_CYCLES) + 5) @(posedge CLK_14M);
        read_reg(4'h0, 8'h00);

        // Motor restart clears the data register
        sw.mode = 8'h00;
        decode_and_check(14, b);
        drive.motor_spinning = 1'b0;
        drive.motor_active   = 1'b0;
        repeat (4) @(posedge CLK_14M);
        read_reg(4'h0, b);                  // Model gives 0xFF with motor off
        drive.motor_active = 1'b1;
        read_reg(4'h0, 8'h00);
        drive.motor_spinning = 1'b1;
        idle_cells(2, 14);
        read_reg(4'h0, 8'h00);              // Still empty before a new byte
        decode_and_check(14, b);

        repeat (4) @(posedge CLK_14M);
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
+incdir+bench
design/iwm_pkg.sv
design/iwm_flux_window.sv
design/iwm_data_latch.sv
design/iwm_read_ctrl.sv
design/iwm_bus_read.sv
design/iwm_flux_top.sv
bench/iwm_flux_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile and run the IWM read path testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module iwm_flux_tb \
    -f build.f -o iwm_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    echo "Compile failed, see $BUILD_LOG"
    exit 1
fi

./obj_dir/iwm_sim > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q '^\*\*\* PASSED \*\*\*$' "$SIM_LOG"; then
    exit 0
fi
echo "Pass message not found in $SIM_LOG"
exit 1
